// File: flist.f
+incdir+verification
src/chdr_types_pkg.sv
src/samp_stream_pkg.sv
src/samp_packer.sv
src/frame_fifo.sv
src/chdr_emitter.sv
src/chdr_framer.sv
verification/chdr_framer_tb.sv

// File: verification/chdr_framer_tb_cases.svh
// Test packets for 32-bit samples; each packet must fit the body buffer and seqnum counts from 0
`ifndef CHDR_FRAMER_TB_CASES_SVH
`define CHDR_FRAMER_TB_CASES_SVH

typedef struct packed {
  logic [7:0]                 n_samp;
  logic                       has_time;
  chdr_types_pkg::chdr_sid_t  sid;
  chdr_types_pkg::chdr_time_t ts;
  logic [31:0]                first;
  logic                       rand_ready;
} case_row_t;

localparam int NUM_CASES = 10;

// Columns: sample count, has_time, sid, timestamp, first sample, random output ready
case_row_t pkt_table [NUM_CASES] = '{
  '{8'd4,  1'b0, 32'h0000_1001, 64'h0000_0000_0000_0000, 32'h1000_0000, 1'b0},
  '{8'd5,  1'b0, 32'h0000_2002, 64'h0000_0000_0000_0000, 32'h2000_0010, 1'b0},
  '{8'd6,  1'b1, 32'hA5A5_0003, 64'h0123_4567_89AB_CDEF, 32'h3000_0000, 1'b0},
  '{8'd1,  1'b0, 32'h0000_0004, 64'h0000_0000_0000_0000, 32'hDEAD_BEEF, 1'b0},
  '{8'd7,  1'b1, 32'h1234_5678, 64'hFEDC_BA98_7654_3210, 32'hFFFF_FFFC, 1'b1},
  '{8'd8,  1'b0, 32'h0BAD_CAFE, 64'h0000_0000_0000_0000, 32'h5000_0000, 1'b1},
  '{8'd3,  1'b1, 32'h0000_7007, 64'h0000_0001_0000_0000, 32'h7000_0100, 1'b1},
  '{8'd12, 1'b0, 32'h8000_0008, 64'h0000_0000_0000_0000, 32'h8888_0000, 1'b1},
  '{8'd2,  1'b1, 32'h0000_9009, 64'h1111_2222_3333_4444, 32'h9000_0000, 1'b0},
  '{8'd9,  1'b0, 32'hFFFF_000A, 64'h0000_0000_0000_0000, 32'hA000_00F0, 1'b0}
};

// Output words of one packet: header, optional time word, then the body
function automatic int unsigned pkt_words(input case_row_t row);
  int unsigned words;
  words = 1 + row.has_time + (row.n_samp + 1) / 2;
  return words;
endfunction

// Word k of a packet, with o_last on top
function automatic logic [64:0] expected_beat(input case_row_t row,
                                              input chdr_types_pkg::chdr_seq_t seq,
                                              input int unsigned k);
  logic [3:0]                flags;
  chdr_types_pkg::chdr_len_t len;
  int unsigned               payload;
  int unsigned               b;
  int unsigned               n_body;
  logic [31:0]               hi;
  logic [31:0]               lo;
  logic [64:0]               word;
  flags    = 4'b0000;
  // has_time sits one below the top flag bit
  flags[2] = row.has_time;
  payload  = row.n_samp * samp_stream_pkg::samp_len_step(32);
  len      = chdr_types_pkg::chdr_len_t'(payload + (row.has_time ? 16 : 8));
  n_body   = (row.n_samp + 1) / 2;
  if (k == 0) begin
    word = {1'b0, flags, seq, len, row.sid};
  end else if (row.has_time && k == 1) begin
    word = {1'b0, row.ts};
  end else begin
    b    = k - 1 - row.has_time;
    hi   = row.first + 32'(2 * b);
    lo   = (2 * b + 1 < row.n_samp) ? row.first + 32'(2 * b + 1) : 32'h0;
    word = {(b == n_body - 1), hi, lo};
  end
  return word;
endfunction

`endif

// File: verification/chdr_framer_tb.sv
// Testbench for chdr_framer with 32-bit samples and USE_SEQ_NUM 0; expects packets in table order
`timescale 1ns/1ps

module chdr_framer_tb;

  logic                       samp_clk;
  logic                       pkt_rst;
  logic [31:0]                samp;
  chdr_types_pkg::chdr_desc_t desc;
  logic                       samp_last;
  logic                       samp_valid;
  logic                       samp_ready;
  logic [63:0]                out_data;
  logic                       out_last;
  logic                       out_valid;
  logic                       out_ready;

  `include "chdr_framer_tb_cases.svh"

  logic [64:0] exp_q [$];
  int unsigned errors;
  int unsigned beats;
  int unsigned in_pkts;
  int unsigned out_pkts;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;
  int unsigned live_cycles;
  int unsigned rnd_seed;
  logic        stalled;
  logic [63:0] held_data;
  logic        held_last;

  chdr_framer #(
    .SAMP_WIDTH  (32),
    .USE_SEQ_NUM (0)
  ) uut (
    .i_samp_clk (samp_clk),
    .i_pkt_rst  (pkt_rst),
    .i_samp     (samp),
    .i_desc     (desc),
    .i_last     (samp_last),
    .i_valid    (samp_valid),
    .o_ready    (samp_ready),
    .o_data     (out_data),
    .o_last     (out_last),
    .o_valid    (out_valid),
    .i_ready    (out_ready)
  );

  always #2 samp_clk = ~samp_clk;

  task automatic report_and_finish();
    $display("Summary: %0d errors, %0d beats checked, %0d packets", errors, beats, out_pkts);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  // Called just after a falling edge, returns after the edge that takes the sample
  task automatic send_sample(input logic [31:0] value, input chdr_types_pkg::chdr_desc_t d,
                             input logic last);
    samp       = value;
    desc       = d;
    samp_last  = last;
    samp_valid = 1'b1;
    #1;
    while (!samp_ready) begin
      @(negedge samp_clk);
      #1;
    end
    @(posedge samp_clk);
  endtask

  //////////////////////////////////////////////////
  // Reset and input stimulus
  //////////////////////////////////////////////////

  initial begin : main
    chdr_types_pkg::chdr_desc_t d;
    int unsigned                total;
    samp_clk    = 1'b0;
    pkt_rst     = 1'b1;
    samp        = '0;
    desc        = '0;
    samp_last   = 1'b0;
    samp_valid  = 1'b0;
    out_ready   = 1'b0;
    errors      = 0;
    beats       = 0;
    in_pkts     = 0;
    out_pkts    = 0;
    cycle_cnt   = 0;
    live_cycles = 0;
    stalled     = 1'b0;
    held_data   = '0;
    held_last   = 1'b0;
    total = 0;
    for (int r = 0; r < NUM_CASES; r++) begin
      for (int unsigned k = 0; k < pkt_words(pkt_table[r]); k++) begin
        exp_q.push_back(expected_beat(pkt_table[r], chdr_types_pkg::chdr_seq_t'(r), k));
      end
      total += pkt_table[r].n_samp + pkt_words(pkt_table[r]);
    end
    cycle_limit = 4 * total + 200;
    repeat (8) @(negedge samp_clk);
    pkt_rst = 1'b0;
    // Packets go in back to back; seqnum and length in the sideband are dummies
    for (int r = 0; r < NUM_CASES; r++) begin
      d           = '0;
      d.flags[2]  = pkt_table[r].has_time;
      d.seqnum    = 12'hA50 + 12'(r);
      d.length    = 16'hBEEF;
      d.sid       = pkt_table[r].sid;
      d.timestamp = pkt_table[r].ts;
      for (int s = 0; s < pkt_table[r].n_samp; s++) begin
        @(negedge samp_clk);
        send_sample(pkt_table[r].first + 32'(s), d, (s == pkt_table[r].n_samp - 1));
      end
      in_pkts++;
    end
    @(negedge samp_clk);
    samp_valid = 1'b0;
    samp_last  = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge samp_clk);
    end
    // Quiet period catches extra beats
    repeat (20) @(posedge samp_clk);
    assert (out_pkts == NUM_CASES) else begin
      errors++;
      $display("mismatch out_pkts: expected %h, got %h", NUM_CASES, out_pkts);
    end
    report_and_finish();
  end

  // Output ready follows the mode of the packet being emitted
  initial begin : ready_drive
    rnd_seed = 39668;
    void'($urandom(rnd_seed));
    forever begin
      @(negedge samp_clk);
      if (out_pkts < NUM_CASES && pkt_table[out_pkts].rand_ready) begin
        out_ready = (($urandom % 2) != 0);
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Output checker
  //////////////////////////////////////////////////

  // Sampled between the falling edge and the next rising edge
  always @(negedge samp_clk) begin : monitor
    logic [64:0] exp;
    #1;
    if (!pkt_rst) begin
      live_cycles++;
    end
    if (pkt_rst || live_cycles <= 2) begin
      assert (!out_valid) else begin
        errors++;
        $display("Output valid was raised during reset or right after it");
      end
    end
    if (!pkt_rst && live_cycles <= 2) begin
      assert (samp_ready) else begin
        errors++;
        $display("Input ready was low after reset although the buffers were empty");
      end
    end
    if (stalled) begin
      assert (out_valid && out_data == held_data && out_last == held_last) else begin
        errors++;
        $display("Output changed while it was held by back-pressure");
      end
    end
    if (out_valid && out_ready) begin
      assert (in_pkts > out_pkts) else begin
        errors++;
        $display("Output beat appeared before its packet was fully accepted");
      end
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("Unexpected output beat after all expected words");
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        assert (out_data === exp[63:0]) else begin
          errors++;
          $display("mismatch o_data: expected %h, got %h (beat %0d)", exp[63:0], out_data, beats);
        end
        assert (out_last === exp[64]) else begin
          errors++;
          $display("mismatch o_last: expected %h, got %h (beat %0d)", exp[64], out_last, beats);
        end
      end
      beats++;
      if (out_last) begin
        out_pkts++;
      end
    end
    stalled   = out_valid && !out_ready;
    held_data = out_data;
    held_last = out_last;
  end

  always @(posedge samp_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not complete within %0d cycles", cycle_limit);
      errors++;
      report_and_finish();
    end
  end

endmodule

// File: src/chdr_framer.sv
// CHDR framer top on one clock; SAMP_WIDTH must be 32 or 64 and only valid/ready flow control is used
`timescale 1ns/1ps

module chdr_framer #(
  parameter int unsigned SAMP_WIDTH      = 32,
  parameter int unsigned BODY_DEPTH_LOG2 = 6,
  parameter int unsigned HDR_DEPTH_LOG2  = 3,
  parameter int unsigned USE_SEQ_NUM     = 0
) (
  input  logic                       i_samp_clk,
  input  logic                       i_pkt_rst,
  input  logic [SAMP_WIDTH-1:0]      i_samp,
  input  chdr_types_pkg::chdr_desc_t i_desc,
  input  logic                       i_last,
  input  logic                       i_valid,
  output logic                       o_ready,
  output logic [63:0]                o_data,
  output logic                       o_last,
  output logic                       o_valid,
  input  logic                       i_ready
);

  localparam int unsigned HDR_WIDTH  = $bits(chdr_types_pkg::chdr_desc_t);
  localparam int unsigned BODY_WIDTH = $bits(samp_stream_pkg::body_word_t);

  // Packer to buffers
  chdr_types_pkg::chdr_desc_t  hdr_in;
  logic                        hdr_in_valid;
  logic                        hdr_in_ready;
  samp_stream_pkg::body_word_t body_in;
  logic                        body_in_valid;
  logic                        body_in_ready;

  // Buffers to emitter
  chdr_types_pkg::chdr_desc_t  hdr_out;
  logic                        hdr_out_valid;
  logic                        hdr_out_ready;
  samp_stream_pkg::body_word_t body_out;
  logic                        body_out_valid;
  logic                        body_out_ready;

  samp_packer #(
    .SAMP_WIDTH (SAMP_WIDTH)
  ) packer (
    .i_samp_clk   (i_samp_clk),
    .i_pkt_rst    (i_pkt_rst),
    .i_samp       (i_samp),
    .i_desc       (i_desc),
    .i_last       (i_last),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .o_body       (body_in),
    .o_body_valid (body_in_valid),
    .i_body_ready (body_in_ready),
    .o_desc       (hdr_in),
    .o_desc_valid (hdr_in_valid),
    .i_desc_ready (hdr_in_ready)
  );

  frame_fifo #(
    .DATA_WIDTH (HDR_WIDTH),
    .DEPTH_LOG2 (HDR_DEPTH_LOG2)
  ) hdr_buf (
    .i_samp_clk (i_samp_clk),
    .i_pkt_rst  (i_pkt_rst),
    .i_wdata    (hdr_in),
    .i_wvalid   (hdr_in_valid),
    .o_wready   (hdr_in_ready),
    .o_rdata    (hdr_out),
    .o_rvalid   (hdr_out_valid),
    .i_rready   (hdr_out_ready)
  );

  frame_fifo #(
    .DATA_WIDTH (BODY_WIDTH),
    .DEPTH_LOG2 (BODY_DEPTH_LOG2)
  ) body_buf (
    .i_samp_clk (i_samp_clk),
    .i_pkt_rst  (i_pkt_rst),
    .i_wdata    (body_in),
    .i_wvalid   (body_in_valid),
    .o_wready   (body_in_ready),
    .o_rdata    (body_out),
    .o_rvalid   (body_out_valid),
    .i_rready   (body_out_ready)
  );

  chdr_emitter #(
    .USE_SEQ_NUM (USE_SEQ_NUM)
  ) emitter (
    .i_samp_clk   (i_samp_clk),
    .i_pkt_rst    (i_pkt_rst),
    .i_desc       (hdr_out),
    .i_desc_valid (hdr_out_valid),
    .o_desc_ready (hdr_out_ready),
    .i_body       (body_out),
    .i_body_valid (body_out_valid),
    .o_body_ready (body_out_ready),
    .o_data       (o_data),
    .o_last       (o_last),
    .o_valid      (o_valid),
    .i_ready      (i_ready)
  );

endmodule

// File: src/chdr_emitter.sv
// CHDR emitter; a packet starts only once its descriptor and first body word are both buffered
`timescale 1ns/1ps

module chdr_emitter #(
  parameter int unsigned USE_SEQ_NUM = 0
) (
  input  logic                        i_samp_clk,
  input  logic                        i_pkt_rst,
  input  chdr_types_pkg::chdr_desc_t  i_desc,
  input  logic                        i_desc_valid,
  output logic                        o_desc_ready,
  input  samp_stream_pkg::body_word_t i_body,
  input  logic                        i_body_valid,
  output logic                        o_body_ready,
  output logic [63:0]                 o_data,
  output logic                        o_last,
  output logic                        o_valid,
  input  logic                        i_ready
);

  chdr_types_pkg::emit_state_t state;
  chdr_types_pkg::emit_state_t state_nxt;
  chdr_types_pkg::chdr_seq_t   seq_cnt;
  chdr_types_pkg::chdr_seq_t   hdr_seq;
  chdr_types_pkg::chdr_len_t   hdr_len;
  logic                        has_time;

  assign has_time = i_desc.flags[chdr_types_pkg::FLAG_HAS_TIME];

  //////////////////////////////////////////////////
  // Packet sequencing FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      chdr_types_pkg::ST_IDLE: begin
        if (i_desc_valid & i_body_valid) begin
          state_nxt = chdr_types_pkg::ST_HEAD;
        end
      end
      chdr_types_pkg::ST_HEAD: begin
        if (i_ready) begin
          state_nxt = has_time ? chdr_types_pkg::ST_TIME : chdr_types_pkg::ST_BODY;
        end
      end
      chdr_types_pkg::ST_TIME: begin
        if (i_ready) begin
          state_nxt = chdr_types_pkg::ST_BODY;
        end
      end
      chdr_types_pkg::ST_BODY: begin
        if (i_ready & i_body_valid & i_body.last) begin
          state_nxt = chdr_types_pkg::ST_IDLE;
        end
      end
      default: state_nxt = chdr_types_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_samp_clk) begin
    if (i_pkt_rst) begin
      state <= chdr_types_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Internal count, one per packet sent
  always_ff @(posedge i_samp_clk) begin
    if (i_pkt_rst) begin
      seq_cnt <= '0;
    end else if (o_valid & i_ready & o_last) begin
      seq_cnt <= seq_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Output word select
  //////////////////////////////////////////////////

  assign hdr_seq = (USE_SEQ_NUM == 1) ? i_desc.seqnum : seq_cnt;
  // Header adds 8 bytes, the time word another 8
  assign hdr_len = i_desc.length + (has_time ? 16'd16 : 16'd8);

  always_comb begin
    case (state)
      chdr_types_pkg::ST_HEAD: o_data = {i_desc.flags, hdr_seq, hdr_len, i_desc.sid};
      chdr_types_pkg::ST_TIME: o_data = i_desc.timestamp;
      default:                 o_data = i_body.data;
    endcase
  end

  assign o_valid = (state == chdr_types_pkg::ST_HEAD) |
                   (state == chdr_types_pkg::ST_TIME) |
                   ((state == chdr_types_pkg::ST_BODY) & i_body_valid);
  assign o_last  = (state == chdr_types_pkg::ST_BODY) & i_body.last;

  // Descriptor leaves with the last word that needs it
  assign o_desc_ready = i_ready & ((state == chdr_types_pkg::ST_TIME) |
                                   ((state == chdr_types_pkg::ST_HEAD) & ~has_time));
  assign o_body_ready = i_ready & (state == chdr_types_pkg::ST_BODY);

endmodule

// File: src/frame_fifo.sv
// Single-clock FIFO of 2**DEPTH_LOG2 entries; read data is unregistered and valid one cycle after write
`timescale 1ns/1ps

module frame_fifo #(
  parameter int unsigned DATA_WIDTH = 64,
  parameter int unsigned DEPTH_LOG2 = 4
) (
  input  logic                  i_samp_clk,
  input  logic                  i_pkt_rst,
  input  logic [DATA_WIDTH-1:0] i_wdata,
  input  logic                  i_wvalid,
  output logic                  o_wready,
  output logic [DATA_WIDTH-1:0] o_rdata,
  output logic                  o_rvalid,
  input  logic                  i_rready
);

  localparam int unsigned DEPTH = 2 ** DEPTH_LOG2;

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  full;
  logic                  wr_en;
  logic                  rd_en;

  assign full     = (count == (DEPTH_LOG2 + 1)'(DEPTH));
  assign o_rvalid = (count != '0);
  assign o_rdata  = mem[rd_ptr];

  // A full FIFO still takes a word when one leaves in the same cycle
  assign o_wready = ~full | i_rready;
  assign wr_en    = i_wvalid & o_wready;
  assign rd_en    = o_rvalid & i_rready;

  always_ff @(posedge i_samp_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_wdata;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge i_samp_clk) begin
    if (i_pkt_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/samp_packer.sv
// Sample packer for SAMP_WIDTH 32 or 64; lengths are counted in whole samples, no partial words
`timescale 1ns/1ps

module samp_packer #(
  parameter int unsigned SAMP_WIDTH = 32
) (
  input  logic                        i_samp_clk,
  input  logic                        i_pkt_rst,
  input  logic [SAMP_WIDTH-1:0]       i_samp,
  input  chdr_types_pkg::chdr_desc_t  i_desc,
  input  logic                        i_last,
  input  logic                        i_valid,
  output logic                        o_ready,
  output samp_stream_pkg::body_word_t o_body,
  output logic                        o_body_valid,
  input  logic                        i_body_ready,
  output chdr_types_pkg::chdr_desc_t  o_desc,
  output logic                        o_desc_valid,
  input  logic                        i_desc_ready
);

  localparam chdr_types_pkg::chdr_len_t LEN_STEP =
    chdr_types_pkg::chdr_len_t'(samp_stream_pkg::samp_len_step(SAMP_WIDTH));

  logic                      accept;
  chdr_types_pkg::chdr_len_t byte_cnt;

  // Both buffers must take a write before a sample is taken
  assign o_ready = i_body_ready & i_desc_ready;
  assign accept  = i_valid & o_ready;

  //////////////////////////////////////////////////
  // Body word packing
  //////////////////////////////////////////////////

  generate
    if (SAMP_WIDTH == 32) begin : g_pack32
      logic        odd;
      logic [31:0] held_samp;

      // Set while one sample waits for its partner
      always_ff @(posedge i_samp_clk) begin
        if (i_pkt_rst) begin
          odd <= 1'b0;
        end else if (accept) begin
          odd <= i_last ? 1'b0 : ~odd;
        end
      end

      always_ff @(posedge i_samp_clk) begin
        if (accept) begin
          held_samp <= i_samp;
        end
      end

      // Earlier sample on top, lone final sample padded with zero
      assign o_body.data  = odd ? {held_samp, i_samp} : {i_samp, 32'h0};
      assign o_body_valid = accept & (i_last | odd);
    end else begin : g_pack64
      assign o_body.data  = i_samp;
      assign o_body_valid = accept;
    end
  endgenerate

  assign o_body.last = i_last;

  //////////////////////////////////////////////////
  // Payload length count
  //////////////////////////////////////////////////

  // Bytes taken so far in the current packet, not counting this beat
  always_ff @(posedge i_samp_clk) begin
    if (i_pkt_rst) begin
      byte_cnt <= '0;
    end else if (accept) begin
      byte_cnt <= i_last ? '0 : byte_cnt + LEN_STEP;
    end
  end

  always_comb begin
    o_desc        = i_desc;
    o_desc.length = byte_cnt + LEN_STEP;
  end

  assign o_desc_valid = accept & i_last;

endmodule

// File: src/samp_stream_pkg.sv
// Sample-side stream types; only 32- and 64-bit sample widths have a defined byte step
package samp_stream_pkg;

  //////////////////////////////////////////////////
  // Body words as held in the body buffer
  //////////////////////////////////////////////////

  localparam int unsigned BODY_WIDTH = 64;

  typedef logic [BODY_WIDTH-1:0] body_data_t;

  // Marks the final word of a packet body
  typedef struct packed {
    logic       last;
    body_data_t data;
  } body_word_t;

  // Byte increment of one input sample
  typedef logic [3:0] samp_step_t;

  // Any width other than 64 is taken as 32
  function automatic samp_step_t samp_len_step(input int unsigned width);
    samp_step_t step;
    step = (width == 64) ? 4'd8 : 4'd4;
    return step;
  endfunction

endpackage

// File: src/chdr_types_pkg.sv
// CHDR format types; the descriptor is 128 bits wide and has_time is bit 2 of the 4-bit flags
package chdr_types_pkg;

  //////////////////////////////////////////////////
  // Field widths of the sideband descriptor
  //////////////////////////////////////////////////

  localparam int unsigned CHDR_FLAGS_W = 4;
  localparam int unsigned CHDR_SEQ_W   = 12;
  localparam int unsigned CHDR_LEN_W   = 16;
  localparam int unsigned CHDR_SID_W   = 32;
  localparam int unsigned CHDR_TIME_W  = 64;

  // Index of the has-time bit inside the flags field
  localparam int unsigned FLAG_HAS_TIME = 2;

  typedef logic [CHDR_FLAGS_W-1:0] chdr_flags_t;
  typedef logic [CHDR_SEQ_W-1:0]   chdr_seq_t;
  typedef logic [CHDR_LEN_W-1:0]   chdr_len_t;
  typedef logic [CHDR_SID_W-1:0]   chdr_sid_t;
  typedef logic [CHDR_TIME_W-1:0]  chdr_time_t;

  // Sideband word and header buffer entry, top bits first
  typedef struct packed {
    chdr_flags_t flags;
    chdr_seq_t   seqnum;
    chdr_len_t   length;
    chdr_sid_t   sid;
    chdr_time_t  timestamp;
  } chdr_desc_t;

  // Output sequencing: header, optional time word, then the body
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HEAD,
    ST_TIME,
    ST_BODY
  } emit_state_t;

endpackage
